// ==== sim.f ====
+incdir+dv
common/crc_pkg.sv
common/frame_pkg.sv
common/crc_feed_if.sv
design/crc32_engine.sv
rx/rx_crc_feeder.sv
rx/rx_frame_checker.sv
tx/tx_crc_appender.sv
design/crc_link_top.sv
dv/crc_link_tb.sv

// ==== dv/crc_frame_table.svh ====
`ifndef CRC_FRAME_TABLE_SVH
`define CRC_FRAME_TABLE_SVH

localparam int NUM_ROWS = 10;

int           row_len      [NUM_ROWS];  // Payload bits.
logic [127:0] row_payload  [NUM_ROWS];  // Word 0 in the top bits, sent MSB first.
bit           row_flip     [NUM_ROWS];  // Corrupt the rx copy.
int           row_flip_pos [NUM_ROWS];  // Frame bit index, CRC starts at len.

task automatic set_row(input int row, input int len, input logic [31:0] w0, input logic [31:0] w1,
                       input logic [31:0] w2, input logic [31:0] w3, input bit flip,
                       input int flip_pos);
  row_len[row]      = len;
  row_payload[row]  = {w0, w1, w2, w3};
  row_flip[row]     = flip;
  row_flip_pos[row] = flip_pos;
endtask

task automatic fill_frame_table();
  //      row len  word 0         word 1         word 2         word 3        flip pos
  set_row(0,  32,  32'h0000_0000, 32'h0,         32'h0,         32'h0,         1'b0, 0);
  set_row(1,  32,  32'hFFFF_FFFF, 32'h0,         32'h0,         32'h0,         1'b0, 0);
  set_row(2,  40,  32'h1234_5678, 32'hAB00_0000, 32'h0,         32'h0,         1'b0, 0);
  set_row(3,  64,  $random(seed), $random(seed), 32'h0,         32'h0,         1'b0, 0);
  set_row(4,  64,  32'hDEAD_BEEF, 32'h0123_4567, 32'h0,         32'h0,         1'b1, 10);
  set_row(5,  96,  $random(seed), $random(seed), $random(seed), 32'h0,         1'b1, 101);
  set_row(6,  128, 32'hCAFE_F00D, 32'h0F1E_2D3C, 32'h4B5A_6978, 32'h8796_9A5B, 1'b0, 0);
  set_row(7,  128, $random(seed), $random(seed), $random(seed), $random(seed), 1'b1, 127);
  set_row(8,  33,  32'h8000_0001, 32'h8000_0000, 32'h0,         32'h0,         1'b0, 0);
  set_row(9,  72,  $random(seed), $random(seed), $random(seed), 32'h0,         1'b1, 103);
endtask

`endif

// ==== dv/crc_link_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module crc_link_tb;

  import crc_pkg::*;
  import frame_pkg::*;

  logic                 CLK;
  logic                 RST;
  logic                 tx_bit;
  logic                 tx_write;
  logic                 tx_term;
  logic                 rx_bit;
  logic                 rx_write;
  logic                 rx_term;
  logic                 tx_line_bit;
  logic                 tx_line_valid;
  logic                 tx_busy;
  logic                 rx_result_valid;
  logic                 rx_result_good;
  logic [LEN_WIDTH-1:0] rx_frame_bits;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     cycles;
  int     cycle_limit;
  int     rx_pulses;
  int     reset_fails;
  logic   tx_bits[$];  // Line bits of the current tx frame.

  `include "crc_frame_table.svh"

  crc_link_top dut
  (
    .CLK             (CLK),
    .RST             (RST),
    .tx_bit          (tx_bit),
    .tx_write        (tx_write),
    .tx_term         (tx_term),
    .rx_bit          (rx_bit),
    .rx_write        (rx_write),
    .rx_term         (rx_term),
    .tx_line_bit     (tx_line_bit),
    .tx_line_valid   (tx_line_valid),
    .tx_busy         (tx_busy),
    .rx_result_valid (rx_result_valid),
    .rx_result_good  (rx_result_good),
    .rx_frame_bits   (rx_frame_bits)
  );

  always
  begin
    #5 CLK = ~CLK;
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      errors++;
      $display("Finished with errors");
      $finish;
    end
  end

  // Collects tx line bits and counts rx result pulses.
  always @(negedge CLK)
  begin
    if (RST && tx_line_valid)
      tx_bits.push_back(tx_line_bit);
    if (RST && rx_result_valid)
      rx_pulses++;
  end

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  // First 32 bits inverted, 32 zeros appended, remainder inverted.
  task automatic crc_model(input logic [127:0] payload, input int len,
                           output logic [CRC_WIDTH-1:0] crc);
    logic [CRC_WIDTH-1:0] r;
    logic                 b;
    logic                 msb;
    r = '0;
    for (int i = 0; i < len + CRC_WIDTH; i++)
    begin
      b = (i < len) ? payload[127-i] : 1'b0;
      if (i < CRC_WIDTH)
        b = ~b;
      msb = r[CRC_WIDTH-1];
      r   = {r[CRC_WIDTH-2:0], b} ^ (msb ? CRC_POLY : '0);
    end
    crc = ~r;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected, inout int fails);
    if (actual !== expected)
    begin
      $display("MISMATCH %s: actual %h, expected %h", name, actual, expected);
      errors++;
      fails++;
    end
  endtask

  task automatic log_test_result(input string name, input int fails);
    tests_run++;
    if (fails != 0)
      tests_failed++;
    $display("%s: %s", name, (fails == 0) ? "pass" : "FAIL");
  endtask

  //////////////////////////////
  // Transmit path
  //////////////////////////////

  task automatic send_tx_frame(input int row);
    int                   len;
    int                   fails;
    logic [CRC_WIDTH-1:0] exp_crc;
    logic [CRC_WIDTH-1:0] got_crc;
    logic [127:0]         got;
    logic [127:0]         want;
    len   = row_len[row];
    fails = 0;
    got   = '0;
    want  = '0;
    crc_model(row_payload[row], len, exp_crc);
    tx_bits.delete();
    for (int i = 0; i < len; i++)
    begin
      @(posedge CLK);
      tx_bit   <= row_payload[row][127-i];
      tx_write <= 1'b1;
    end
    @(posedge CLK);
    tx_write <= 1'b0;
    tx_bit   <= 1'b0;
    @(posedge CLK);
    tx_term <= 1'b1;
    @(posedge CLK);
    tx_term <= 1'b0;
    do
      @(negedge CLK);
    while (tx_busy);  // Frame ends when busy falls.
    check_value("tx_line_valid bit count", tx_bits.size(), len + CRC_WIDTH, fails);
    check_value("tx_line_valid after busy", tx_line_valid, 1'b0, fails);
    if (tx_bits.size() == len + CRC_WIDTH)
    begin
      for (int i = 0; i < len; i++)
      begin
        got[127-i]  = tx_bits[i];
        want[127-i] = row_payload[row][127-i];
      end
      for (int k = 0; 32 * k < len; k++)
        check_value($sformatf("tx_line_bit payload word %0d", k), got[127-32*k -: 32],
                    want[127-32*k -: 32], fails);
      for (int j = 0; j < CRC_WIDTH; j++)
        got_crc[CRC_WIDTH-1-j] = tx_bits[len+j];
      check_value("tx_line_bit crc", got_crc, exp_crc, fails);
    end
    log_test_result($sformatf("tx row %0d, %0d payload bits", row, len), fails);
  endtask

  //////////////////////////////
  // Receive path
  //////////////////////////////

  task automatic send_rx_frame(input int row);
    int                   len;
    int                   fails;
    int                   wait_cycles;
    logic                 frame_bit;
    logic [CRC_WIDTH-1:0] exp_crc;
    len         = row_len[row];
    fails       = 0;
    wait_cycles = 0;
    crc_model(row_payload[row], len, exp_crc);
    for (int i = 0; i < len + CRC_WIDTH; i++)
    begin
      if (i < len)
        frame_bit = row_payload[row][127-i];
      else
        frame_bit = exp_crc[CRC_WIDTH-1-(i-len)];
      if (row_flip[row] && (i == row_flip_pos[row]))
        frame_bit = ~frame_bit;  // Corrupted copy.
      @(posedge CLK);
      rx_bit   <= frame_bit;
      rx_write <= 1'b1;
    end
    @(posedge CLK);
    rx_write <= 1'b0;
    rx_bit   <= 1'b0;
    @(posedge CLK);
    rx_term <= 1'b1;
    @(posedge CLK);  // Term taken on this edge.
    rx_term <= 1'b0;
    @(negedge CLK);
    while (!rx_result_valid)
    begin
      @(negedge CLK);
      wait_cycles++;
    end
    check_value("rx_result_valid latency", wait_cycles, 35, fails);
    check_value("rx_result_good", rx_result_good, !row_flip[row], fails);
    check_value("rx_frame_bits", rx_frame_bits, len, fails);
    @(negedge CLK);
    check_value("rx_result_valid pulse width", rx_result_valid, 1'b0, fails);
    check_value("rx_result_valid pulse count", rx_pulses, row + 1, fails);
    log_test_result($sformatf("rx row %0d, %0d payload bits, flip %0d", row, len,
                              row_flip[row]), fails);
  endtask

  task automatic run_tx_rows();
    for (int row = 0; row < NUM_ROWS; row++)
      send_tx_frame(row);
  endtask

  // Each frame starts two cycles after the previous result.
  task automatic run_rx_rows();
    for (int row = 0; row < NUM_ROWS; row++)
      send_rx_frame(row);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    CLK          = 1'b0;
    RST          = 1'b0;
    tx_bit       = 1'b0;
    tx_write     = 1'b0;
    tx_term      = 1'b0;
    rx_bit       = 1'b0;
    rx_write     = 1'b0;
    rx_term      = 1'b0;
    seed         = 32'h73a33a03;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    rx_pulses    = 0;
    reset_fails  = 0;
    fill_frame_table();
    cycle_limit = 0;
    for (int row = 0; row < NUM_ROWS; row++)
      cycle_limit += 2 * row_len[row] + 100;

    repeat (4) @(posedge CLK);
    RST <= 1'b1;
    @(negedge CLK);
    check_value("tx_line_valid", tx_line_valid, 1'b0, reset_fails);
    check_value("tx_busy", tx_busy, 1'b0, reset_fails);
    check_value("rx_result_valid", rx_result_valid, 1'b0, reset_fails);
    log_test_result("idle after reset", reset_fails);

    fork
      run_tx_rows();
      run_rx_rows();
    join

    $display("Summary: %0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
             errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/crc_link_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module crc_link_top
(
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            tx_bit,
  input  logic                            tx_write,
  input  logic                            tx_term,
  input  logic                            rx_bit,
  input  logic                            rx_write,
  input  logic                            rx_term,
  output logic                            tx_line_bit,
  output logic                            tx_line_valid,
  output logic                            tx_busy,
  output logic                            rx_result_valid,
  output logic                            rx_result_good,
  output logic [frame_pkg::LEN_WIDTH-1:0] rx_frame_bits
);

  logic rx_safe;   // Feeder compare result.
  logic rx_clear;  // Checker ends the frame.

  crc_feed_if tx_feed ();
  crc_feed_if rx_feed ();

  //////////////////////////////
  // Transmit path
  //////////////////////////////

  tx_crc_appender tx_appender
  (
    .CLK           (CLK),
    .RST           (RST),
    .tx_bit        (tx_bit),
    .tx_write      (tx_write),
    .tx_term       (tx_term),
    .feed          (tx_feed),
    .tx_line_bit   (tx_line_bit),
    .tx_line_valid (tx_line_valid),
    .tx_busy       (tx_busy)
  );

  crc32_engine tx_engine
  (
    .CLK  (CLK),
    .RST  (RST),
    .feed (tx_feed)
  );

  //////////////////////////////
  // Receive path
  //////////////////////////////

  rx_crc_feeder rx_feeder
  (
    .CLK      (CLK),
    .RST      (RST),
    .rx_bit   (rx_bit),
    .rx_write (rx_write),
    .rx_term  (rx_term),
    .rx_clear (rx_clear),
    .feed     (rx_feed),
    .safe     (rx_safe)
  );

  crc32_engine rx_engine
  (
    .CLK  (CLK),
    .RST  (RST),
    .feed (rx_feed)
  );

  rx_frame_checker rx_checker
  (
    .CLK             (CLK),
    .RST             (RST),
    .rx_write        (rx_write),
    .done            (rx_feed.done),
    .safe            (rx_safe),
    .rx_clear        (rx_clear),
    .rx_result_valid (rx_result_valid),
    .rx_result_good  (rx_result_good),
    .rx_frame_bits   (rx_frame_bits)
  );

endmodule

`default_nettype wire

// ==== tx/tx_crc_appender.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_crc_appender
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       tx_bit,
  input  logic       tx_write,
  input  logic       tx_term,
  crc_feed_if.feeder feed,
  output logic       tx_line_bit,
  output logic       tx_line_valid,
  output logic       tx_busy
);

  import crc_pkg::*;

  typedef enum logic [1:0]
  {
    S_PAYLOAD,
    S_WAIT,
    S_SHIFT
  } phase_t;

  phase_t                     phase;
  logic [FLUSH_CNT_WIDTH-1:0] cnt;     // Leading bits, later CRC bits left.
  logic [CRC_WIDTH-1:0]       crc_sr;
  logic                       clear_q;
  logic                       take;
  logic                       load_crc;

  assign take     = tx_write && (phase == S_PAYLOAD) && !clear_q;
  assign load_crc = (phase == S_WAIT) && feed.done;

  assign feed.write    = take;
  assign feed.data_bit = (cnt < CRC_WIDTH) ? ~tx_bit : tx_bit;
  assign feed.term     = tx_term && (phase == S_PAYLOAD) && !clear_q;
  assign feed.clear    = clear_q;

  //////////////////////////////
  // Line data
  //////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (take)
      tx_line_bit <= tx_bit;
    else if (load_crc)
    begin
      tx_line_bit <= feed.crc[CRC_WIDTH-1];  // MSB goes out first.
      crc_sr      <= {feed.crc[CRC_WIDTH-2:0], 1'b0};
    end
    else if (phase == S_SHIFT)
    begin
      tx_line_bit <= crc_sr[CRC_WIDTH-1];
      crc_sr      <= {crc_sr[CRC_WIDTH-2:0], 1'b0};
    end
  end

  //////////////////////////////
  // Phase control
  //////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      phase         <= S_PAYLOAD;
      cnt           <= '0;
      tx_line_valid <= 1'b0;
      tx_busy       <= 1'b0;
      clear_q       <= 1'b0;
    end
    else
    begin
      clear_q <= 1'b0;
      case (phase)
        S_PAYLOAD:
        begin
          tx_line_valid <= take;
          if (clear_q)
            tx_busy <= 1'b0;  // Frame fully ended.
          if (take)
          begin
            tx_busy <= 1'b1;
            if (cnt < CRC_WIDTH)
              cnt <= cnt + 1'b1;
          end
          if (feed.term)
          begin
            tx_busy <= 1'b1;
            phase   <= S_WAIT;
          end
        end
        S_WAIT:
        begin
          if (feed.done)
          begin
            phase         <= S_SHIFT;
            tx_line_valid <= 1'b1;
            cnt           <= FLUSH_CNT_WIDTH'(CRC_WIDTH - 1);
          end
        end
        S_SHIFT:
        begin
          if (cnt == '0)
          begin
            phase         <= S_PAYLOAD;
            tx_line_valid <= 1'b0;
            clear_q       <= 1'b1;  // Resets the engine for the next frame.
          end
          else
            cnt <= cnt - 1'b1;
        end
        default:
          phase <= S_PAYLOAD;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rx/rx_frame_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_frame_checker
(
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           rx_write,
  input  logic                           done,
  input  logic                           safe,
  output logic                           rx_clear,
  output logic                           rx_result_valid,
  output logic                           rx_result_good,
  output logic [frame_pkg::LEN_WIDTH-1:0] rx_frame_bits
);

  import crc_pkg::*;
  import frame_pkg::*;

  logic [LEN_WIDTH-1:0] bit_cnt;  // Frame bits including the CRC.
  logic                 done_q;
  logic                 done_rise;
  logic                 long_enough;

  assign done_rise   = done && !done_q;
  assign long_enough = (bit_cnt >= LEN_WIDTH'(MIN_PAYLOAD_BITS + CRC_WIDTH));

  //////////////////////////////
  // Per-frame sequencing
  //////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      bit_cnt         <= '0;
      done_q          <= 1'b0;
      rx_result_valid <= 1'b0;
      rx_clear        <= 1'b0;
    end
    else
    begin
      done_q          <= done;
      rx_result_valid <= done_rise;
      rx_clear        <= rx_result_valid;  // One cycle after the verdict.

      if (rx_result_valid)
        bit_cnt <= '0;
      else if (rx_write)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Verdict and length stay until the next frame reports.
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      rx_result_good <= 1'b0;
      rx_frame_bits  <= '0;
    end
    else if (done_rise)
    begin
      rx_result_good <= safe && long_enough;
      rx_frame_bits  <= bit_cnt - LEN_WIDTH'(CRC_WIDTH);
    end
  end

endmodule

`default_nettype wire

// ==== rx/rx_crc_feeder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_crc_feeder
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       rx_bit,
  input  logic       rx_write,
  input  logic       rx_term,
  input  logic       rx_clear,
  crc_feed_if.feeder feed,
  output logic       safe
);

  import crc_pkg::*;

  logic [CRC_WIDTH-1:0]       hold_q;  // Last CRC_WIDTH bits of the frame.
  logic [FLUSH_CNT_WIDTH-1:0] cnt;
  logic                       terminating;
  logic                       primed;
  logic                       take;
  logic                       in_bit;

  assign primed = (cnt == FLUSH_CNT_WIDTH'(CRC_WIDTH));
  assign take   = rx_write && !terminating;
  assign in_bit = primed ? rx_bit : ~rx_bit;  // Leading bits go in inverted.

  // Oldest held bit leaves only once the hold register is full.
  assign feed.data_bit = hold_q[CRC_WIDTH-1];
  assign feed.write    = take && primed;
  assign feed.term     = rx_term;
  assign feed.clear    = rx_clear;

  always_ff @(posedge CLK)
  begin
    if (take)
      hold_q <= {hold_q[CRC_WIDTH-2:0], in_bit};
  end

  always_ff @(posedge CLK)
  begin
    if (!RST || rx_clear)
    begin
      cnt         <= '0;
      terminating <= 1'b0;
      safe        <= 1'b0;
    end
    else
    begin
      if (take && !primed)
        cnt <= cnt + 1'b1;
      if (rx_term)
        terminating <= 1'b1;
      safe <= terminating && (hold_q == feed.crc);  // Received CRC vs. computed.
    end
  end

endmodule

`default_nettype wire

// ==== design/crc32_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module crc32_engine
(
  input  logic       CLK,
  input  logic       RST,
  crc_feed_if.engine feed
);

  import crc_pkg::*;

  logic [CRC_WIDTH-1:0]       crc_q;
  logic [FLUSH_CNT_WIDTH-1:0] flush_cnt;
  logic                       terminal;   // Message ended, flushing zeros.
  logic                       flush_end;
  logic                       shift_en;
  logic                       in_bit;
  logic [CRC_WIDTH-1:0]       poly_mask;

  // During the flush only zeros enter, one per cycle.
  assign shift_en  = terminal ? (flush_cnt != '0) : feed.write;
  assign in_bit    = terminal ? 1'b0 : feed.data_bit;
  assign poly_mask = crc_q[CRC_WIDTH-1] ? CRC_POLY : '0;

  assign feed.crc = ~crc_q;

  //////////////////////////////
  // Divider and flush control
  //////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (!RST || feed.clear)
    begin
      crc_q     <= '0;
      flush_cnt <= '0;
      terminal  <= 1'b0;
      flush_end <= 1'b0;
      feed.done <= 1'b0;
    end
    else
    begin
      if (feed.term && !terminal)
      begin
        terminal  <= 1'b1;
        flush_cnt <= FLUSH_CNT_WIDTH'(FLUSH_COUNT);
      end

      if (shift_en)
      begin
        crc_q <= {crc_q[CRC_WIDTH-2:0], in_bit} ^ poly_mask;
        if (terminal)
          flush_cnt <= flush_cnt - 1'b1;
      end

      // Remainder settles a cycle before done is raised.
      if (terminal && (flush_cnt == '0))
        flush_end <= 1'b1;

      if (flush_end)
        feed.done <= 1'b1;  // Held until clear.
    end
  end

endmodule

`default_nettype wire

// ==== common/crc_feed_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Bit stream from a feeding stage into one CRC engine, result back.
interface crc_feed_if;

  import crc_pkg::*;

  logic                 data_bit;  // Bit to divide.
  logic                 write;     // Strobe for data_bit.
  logic                 term;      // One-cycle end of message.
  logic                 clear;     // Return engine to idle.
  logic                 done;      // Flush finished, crc is final.
  logic [CRC_WIDTH-1:0] crc;       // Complemented remainder.

  modport feeder
  (
    output data_bit, write, term, clear,
    input  done, crc
  );

  modport engine
  (
    input  data_bit, write, term, clear,
    output done, crc
  );

endinterface

`default_nettype wire

// ==== common/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

  //////////////////////////////
  // Frame size limits
  //////////////////////////////

  localparam int MIN_PAYLOAD_BITS = 32;  // Below this the CRC rule does not hold.

  localparam int MAX_FRAME_BITS = 512;  // Payload plus trailing CRC.

  // Bit counters and length ports.
  localparam int LEN_WIDTH = $clog2(MAX_FRAME_BITS + 1);

endpackage

`default_nettype wire

// ==== common/crc_pkg.sv ====
`default_nettype none

package crc_pkg;

  //////////////////////////////
  // CRC-32 divider constants
  //////////////////////////////

  localparam int CRC_WIDTH = 32;

  // Generator polynomial, MSB-first form without the x^32 term.
  localparam logic [CRC_WIDTH-1:0] CRC_POLY = 32'h04C1_1DB7;

  localparam int FLUSH_COUNT = CRC_WIDTH;  // Zero bits shifted after term.

  // Wide enough to hold FLUSH_COUNT itself.
  localparam int FLUSH_CNT_WIDTH = $clog2(FLUSH_COUNT + 1);

endpackage

`default_nettype wire
